// ==== common/lj_pkg.sv ====
// LJ force unit shared definitions
`default_nettype none

package lj_pkg;

	// Lane count and particle data widths
	localparam int NUM_FILTER = 4;
	localparam int LANE_W = $clog2(NUM_FILTER);
	localparam int ID_W = 12;
	localparam int COORD_W = 16;
	localparam int D_W = 17;
	localparam int R2_W = 36;

	// Pairs pass only strictly below this squared distance
	localparam int CUTOFF_2 = 16384;
	localparam int IDX_W = 14;

	// Lookup index fields, seg/bin/frac from msb down
	localparam int SEG_W = 2;
	localparam int BIN_W = 4;
	localparam int FRAC_W = 8;
	localparam int LOOKUP_NUM = 64;

	// Lane buffer geometry
	localparam int BUF_DEPTH = 8;
	localparam int BUF_AW = 3;

	// Pipeline latencies in cycles
	localparam int R2_LAT = 3;
	localparam int FORCE_LAT = 4;

	// Force datapath widths
	localparam int MAG_W = 16;
	localparam int FORCE_W = 32;

	typedef struct packed {
		logic [SEG_W-1:0] seg;
		logic [BIN_W-1:0] bin;
		logic [FRAC_W-1:0] frac;
	} r2_idx_t;

	// Same bits, raw r2 on the filter side, table index on the force side
	typedef union packed {
		logic [IDX_W-1:0] raw;
		r2_idx_t idx;
	} r2_word_t;

	// Force magnitude table, (64 - a)^2, entry 64 is zero
	function automatic logic signed [MAG_W-1:0] lj_table(input int a);
		return MAG_W'((LOOKUP_NUM - a) * (LOOKUP_NUM - a));
	endfunction

endpackage

`default_nettype wire

// ==== filter_bank/filter_logic.sv ====
// Filter lane with r2 pipeline and pair buffer
`timescale 1ns/1ps
`default_nettype none

module filter_logic
(
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic [lj_pkg::ID_W-1:0] ref_id,
	input  logic [lj_pkg::ID_W-1:0] nbr_id,
	input  logic signed [lj_pkg::COORD_W-1:0] ref_x,
	input  logic signed [lj_pkg::COORD_W-1:0] ref_y,
	input  logic signed [lj_pkg::COORD_W-1:0] ref_z,
	input  logic signed [lj_pkg::COORD_W-1:0] nbr_x,
	input  logic signed [lj_pkg::COORD_W-1:0] nbr_y,
	input  logic signed [lj_pkg::COORD_W-1:0] nbr_z,
	input  logic pop,
	output logic buf_valid,
	output lj_pkg::r2_word_t buf_r2,
	output logic signed [lj_pkg::D_W-1:0] buf_dx,
	output logic signed [lj_pkg::D_W-1:0] buf_dy,
	output logic signed [lj_pkg::D_W-1:0] buf_dz,
	output logic [lj_pkg::ID_W-1:0] buf_ref_id,
	output logic [lj_pkg::ID_W-1:0] buf_nbr_id,
	output logic back_pressure,
	output logic idle
);
	import lj_pkg::*;

	// Stage 1 displacement, stage 2 squares
	logic s1_valid, s2_valid;
	logic signed [D_W-1:0] s1_dx, s1_dy, s1_dz, s2_dx, s2_dy, s2_dz;
	logic [ID_W-1:0] s1_ref_id, s1_nbr_id, s2_ref_id, s2_nbr_id;
	logic [2*D_W-1:0] s2_sq_x, s2_sq_y, s2_sq_z;
	logic [R2_W-1:0] s3_sum;
	r2_word_t r2_in;
	logic push, do_pop;

	// Register FIFO storage
	r2_word_t mem_r2 [BUF_DEPTH];
	logic signed [D_W-1:0] mem_dx [BUF_DEPTH];
	logic signed [D_W-1:0] mem_dy [BUF_DEPTH];
	logic signed [D_W-1:0] mem_dz [BUF_DEPTH];
	logic [ID_W-1:0] mem_ref_id [BUF_DEPTH];
	logic [ID_W-1:0] mem_nbr_id [BUF_DEPTH];
	logic [BUF_AW-1:0] wr_ptr, rd_ptr;
	logic [BUF_AW:0] count;
	logic [1:0] inflight;
	logic [BUF_AW+1:0] used;

	always_ff @(posedge clk)
	begin
		// Neighbour minus reference, sign extended
		s1_dx <= nbr_x - ref_x;
		s1_dy <= nbr_y - ref_y;
		s1_dz <= nbr_z - ref_z;
		s1_ref_id <= ref_id;
		s1_nbr_id <= nbr_id;
		s2_sq_x <= s1_dx * s1_dx;
		s2_sq_y <= s1_dy * s1_dy;
		s2_sq_z <= s1_dz * s1_dz;
		s2_dx <= s1_dx;
		s2_dy <= s1_dy;
		s2_dz <= s1_dz;
		s2_ref_id <= s1_ref_id;
		s2_nbr_id <= s1_nbr_id;
		if (rst)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= in_valid;
			s2_valid <= s1_valid;
		end
	end

	// Stage 3 sum and cutoff, survivors go straight into the buffer
	assign s3_sum = R2_W'(s2_sq_x) + R2_W'(s2_sq_y) + R2_W'(s2_sq_z);
	assign push = s2_valid && (s3_sum < R2_W'(CUTOFF_2));
	assign r2_in.raw = s3_sum[IDX_W-1:0];

	assign buf_valid = (count != '0);
	assign do_pop = pop && buf_valid;

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem_r2[wr_ptr] <= r2_in;
			mem_dx[wr_ptr] <= s2_dx;
			mem_dy[wr_ptr] <= s2_dy;
			mem_dz[wr_ptr] <= s2_dz;
			mem_ref_id[wr_ptr] <= s2_ref_id;
			mem_nbr_id[wr_ptr] <= s2_nbr_id;
		end
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !push)
				count <= count - 1'b1;
		end
	end

	// Head of buffer
	assign buf_r2 = mem_r2[rd_ptr];
	assign buf_dx = mem_dx[rd_ptr];
	assign buf_dy = mem_dy[rd_ptr];
	assign buf_dz = mem_dz[rd_ptr];
	assign buf_ref_id = mem_ref_id[rd_ptr];
	assign buf_nbr_id = mem_nbr_id[rd_ptr];

	// Pairs still in the r2 stages count as taken slots
	assign inflight = {1'b0, s1_valid} + {1'b0, s2_valid};
	assign used = (BUF_AW+2)'(count) + (BUF_AW+2)'(inflight);
	assign back_pressure = (used >= (BUF_AW+2)'(BUF_DEPTH - R2_LAT));
	assign idle = !buf_valid && !s1_valid && !s2_valid;

	// Source honours back_pressure, so the buffer never overflows
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		push |-> count != (BUF_AW+1)'(BUF_DEPTH));
	// Arbiter only grants lanes holding a pair
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop |-> buf_valid);

endmodule

`default_nettype wire

// ==== filter_bank/filter_arbiter.sv ====
// Round-robin lane arbiter
`timescale 1ns/1ps
`default_nettype none

module filter_arbiter
(
	input  logic clk,
	input  logic rst,
	input  logic [lj_pkg::NUM_FILTER-1:0] request,
	output logic [lj_pkg::NUM_FILTER-1:0] grant
);
	import lj_pkg::*;

	logic [LANE_W-1:0] last, idx, grant_idx;
	logic found;

	// Search starts one lane past the last winner
	always_comb
	begin
		grant = '0;
		found = 1'b0;
		grant_idx = last;
		idx = last;
		for (int i = 1; i <= NUM_FILTER; i++)
		begin
			idx = LANE_W'((int'(last) + i) % NUM_FILTER);
			if (!found && request[idx])
			begin
				found = 1'b1;
				grant_idx = idx;
				grant[idx] = 1'b1;
			end
		end
	end

	// Lane 0 has first priority after reset
	always_ff @(posedge clk)
	begin
		if (rst)
			last <= LANE_W'(NUM_FILTER - 1);
		else if (found)
			last <= grant_idx;
	end

	a_grant_ok: assert property (@(posedge clk) disable iff (rst)
		$onehot0(grant) && ((grant & ~request) == '0));

endmodule

`default_nettype wire

// ==== filter_bank/filter_bank.sv ====
// Filter lanes with arbitration
`timescale 1ns/1ps
`default_nettype none

module filter_bank
(
	input  logic clk,
	input  logic rst,
	input  logic [lj_pkg::NUM_FILTER-1:0] in_valid,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::ID_W-1:0] ref_id,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::ID_W-1:0] nbr_id,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] ref_x,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] ref_y,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] ref_z,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] nbr_x,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] nbr_y,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] nbr_z,
	output logic pair_valid,
	output lj_pkg::r2_word_t pair_r2,
	output logic signed [lj_pkg::D_W-1:0] pair_dx,
	output logic signed [lj_pkg::D_W-1:0] pair_dy,
	output logic signed [lj_pkg::D_W-1:0] pair_dz,
	output logic [lj_pkg::ID_W-1:0] pair_ref_id,
	output logic [lj_pkg::ID_W-1:0] pair_nbr_id,
	output logic [lj_pkg::NUM_FILTER-1:0] back_pressure,
	output logic all_empty
);
	import lj_pkg::*;

	// Per-lane buffer heads
	logic [NUM_FILTER-1:0] lane_valid, lane_grant, lane_idle;
	r2_word_t [NUM_FILTER-1:0] lane_r2;
	logic [NUM_FILTER-1:0][D_W-1:0] lane_dx, lane_dy, lane_dz;
	logic [NUM_FILTER-1:0][ID_W-1:0] lane_ref_id, lane_nbr_id;

	// Granted head, before the output register
	r2_word_t sel_r2;
	logic [D_W-1:0] sel_dx, sel_dy, sel_dz;
	logic [ID_W-1:0] sel_ref_id, sel_nbr_id;

	for (genvar i = 0; i < NUM_FILTER; i++)
	begin : g_lane
		filter_logic filter_logic_i
		(
			.clk(clk), .rst(rst), .in_valid(in_valid[i]),
			.ref_id(ref_id[i]), .nbr_id(nbr_id[i]),
			.ref_x(ref_x[i]), .ref_y(ref_y[i]), .ref_z(ref_z[i]),
			.nbr_x(nbr_x[i]), .nbr_y(nbr_y[i]), .nbr_z(nbr_z[i]),
			.pop(lane_grant[i]), .buf_valid(lane_valid[i]), .buf_r2(lane_r2[i]),
			.buf_dx(lane_dx[i]), .buf_dy(lane_dy[i]), .buf_dz(lane_dz[i]),
			.buf_ref_id(lane_ref_id[i]), .buf_nbr_id(lane_nbr_id[i]),
			.back_pressure(back_pressure[i]), .idle(lane_idle[i])
		);
	end

	// Grant doubles as the lane's pop
	filter_arbiter filter_arbiter_i
	(
		.clk(clk),
		.rst(rst),
		.request(lane_valid),
		.grant(lane_grant)
	);

	// One-hot select of the granted head
	always_comb
	begin
		sel_r2 = '0;
		sel_dx = '0;
		sel_dy = '0;
		sel_dz = '0;
		sel_ref_id = '0;
		sel_nbr_id = '0;
		for (int i = 0; i < NUM_FILTER; i++)
		begin
			if (lane_grant[i])
			begin
				sel_r2 = lane_r2[i];
				sel_dx = lane_dx[i];
				sel_dy = lane_dy[i];
				sel_dz = lane_dz[i];
				sel_ref_id = lane_ref_id[i];
				sel_nbr_id = lane_nbr_id[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		pair_r2 <= sel_r2;
		pair_dx <= sel_dx;
		pair_dy <= sel_dy;
		pair_dz <= sel_dz;
		pair_ref_id <= sel_ref_id;
		pair_nbr_id <= sel_nbr_id;
		if (rst)
			pair_valid <= 1'b0;
		else
			pair_valid <= |lane_grant;
	end

	assign all_empty = &lane_idle;

endmodule

`default_nettype wire

// ==== src/lj_force_pipeline.sv ====
// LJ force interpolation pipeline
`timescale 1ns/1ps
`default_nettype none

module lj_force_pipeline
(
	input  logic clk,
	input  logic rst,
	input  logic pair_valid,
	input  lj_pkg::r2_word_t pair_r2,
	input  logic signed [lj_pkg::D_W-1:0] pair_dx,
	input  logic signed [lj_pkg::D_W-1:0] pair_dy,
	input  logic signed [lj_pkg::D_W-1:0] pair_dz,
	output logic force_valid,
	output logic signed [lj_pkg::FORCE_W-1:0] force_x,
	output logic signed [lj_pkg::FORCE_W-1:0] force_y,
	output logic signed [lj_pkg::FORCE_W-1:0] force_z
);
	import lj_pkg::*;

	logic s1_valid, s2_valid, s3_valid;
	logic [SEG_W+BIN_W-1:0] addr;
	logic signed [MAG_W-1:0] s1_t0, s1_t1, s2_mag, mag_next;
	logic [FRAC_W-1:0] s1_frac;
	logic signed [D_W-1:0] s1_dx, s1_dy, s1_dz, s2_dx, s2_dy, s2_dz;
	logic signed [MAG_W:0] diff;
	logic signed [MAG_W+FRAC_W+1:0] interp;
	logic signed [FORCE_W-1:0] s3_fx, s3_fy, s3_fz;

	// Table address a = seg*16 + bin
	assign addr = {pair_r2.idx.seg, pair_r2.idx.bin};

	// Stage 2 first-order interpolation between entries a and a+1
	assign diff = s1_t1 - s1_t0;
	assign interp = diff * $signed({1'b0, s1_frac});
	assign mag_next = s1_t0 + MAG_W'(interp >>> FRAC_W);

	always_ff @(posedge clk)
	begin
		// Stage 1 table fetch
		s1_t0 <= lj_table(int'(addr));
		s1_t1 <= lj_table(int'(addr) + 1);
		s1_frac <= pair_r2.idx.frac;
		s1_dx <= pair_dx;
		s1_dy <= pair_dy;
		s1_dz <= pair_dz;
		s2_mag <= mag_next;
		s2_dx <= s1_dx;
		s2_dy <= s1_dy;
		s2_dz <= s1_dz;
		// Stage 3 scale the displacement
		s3_fx <= s2_mag * s2_dx;
		s3_fy <= s2_mag * s2_dy;
		s3_fz <= s2_mag * s2_dz;
		// Stage 4 output register
		force_x <= s3_fx;
		force_y <= s3_fy;
		force_z <= s3_fz;
		if (rst)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			force_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= pair_valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
			force_valid <= s3_valid;
		end
	end

	// Interpolated magnitude stays between its two table entries
	a_mag_bounded: assert property (@(posedge clk) disable iff (rst)
		s1_valid |-> (mag_next <= s1_t0) && (mag_next >= s1_t1));

endmodule

`default_nettype wire

// ==== src/lj_force_eval_unit.sv ====
// LJ force evaluation unit top level
`timescale 1ns/1ps
`default_nettype none

module lj_force_eval_unit
(
	input  logic clk,
	input  logic rst,
	input  logic [lj_pkg::NUM_FILTER-1:0] in_valid,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::ID_W-1:0] ref_id,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::ID_W-1:0] nbr_id,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] ref_x,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] ref_y,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] ref_z,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] nbr_x,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] nbr_y,
	input  logic [lj_pkg::NUM_FILTER-1:0][lj_pkg::COORD_W-1:0] nbr_z,
	output logic [lj_pkg::ID_W-1:0] ref_id_out,
	output logic [lj_pkg::ID_W-1:0] nbr_id_out,
	output logic signed [lj_pkg::FORCE_W-1:0] force_x,
	output logic signed [lj_pkg::FORCE_W-1:0] force_y,
	output logic signed [lj_pkg::FORCE_W-1:0] force_z,
	output logic force_valid,
	output logic [lj_pkg::NUM_FILTER-1:0] back_pressure,
	output logic all_empty
);
	import lj_pkg::*;

	// Bank to pipeline
	logic pair_valid;
	r2_word_t pair_r2;
	logic signed [D_W-1:0] pair_dx, pair_dy, pair_dz;
	logic [ID_W-1:0] pair_ref_id, pair_nbr_id;

	// IDs ride along beside the force pipeline
	logic [FORCE_LAT-1:0][ID_W-1:0] ref_id_dly, nbr_id_dly;

	filter_bank filter_bank_i
	(
		.clk(clk), .rst(rst), .in_valid(in_valid),
		.ref_id(ref_id), .nbr_id(nbr_id),
		.ref_x(ref_x), .ref_y(ref_y), .ref_z(ref_z),
		.nbr_x(nbr_x), .nbr_y(nbr_y), .nbr_z(nbr_z),
		.pair_valid(pair_valid), .pair_r2(pair_r2),
		.pair_dx(pair_dx), .pair_dy(pair_dy), .pair_dz(pair_dz),
		.pair_ref_id(pair_ref_id), .pair_nbr_id(pair_nbr_id),
		.back_pressure(back_pressure), .all_empty(all_empty)
	);

	lj_force_pipeline lj_force_pipeline_i
	(
		.clk(clk), .rst(rst), .pair_valid(pair_valid), .pair_r2(pair_r2),
		.pair_dx(pair_dx), .pair_dy(pair_dy), .pair_dz(pair_dz),
		.force_valid(force_valid),
		.force_x(force_x), .force_y(force_y), .force_z(force_z)
	);

	// Same depth as the force pipeline
	always_ff @(posedge clk)
	begin
		ref_id_dly <= {ref_id_dly[FORCE_LAT-2:0], pair_ref_id};
		nbr_id_dly <= {nbr_id_dly[FORCE_LAT-2:0], pair_nbr_id};
	end

	assign ref_id_out = ref_id_dly[FORCE_LAT-1];
	assign nbr_id_out = nbr_id_dly[FORCE_LAT-1];

endmodule

`default_nettype wire

// ==== sim/lj_force_eval_tb.sv ====
// LJ force unit testbench
`timescale 1ns/1ps
`default_nettype none

module lj_force_eval_tb;
	import lj_pkg::*;

	localparam int ID_NUM = 1 << ID_W;
	localparam int PAIR_LAT = R2_LAT + 1 + FORCE_LAT;

	logic clk;
	logic rst;
	logic [NUM_FILTER-1:0] in_valid;
	logic [NUM_FILTER-1:0][ID_W-1:0] ref_id, nbr_id;
	logic [NUM_FILTER-1:0][COORD_W-1:0] ref_x, ref_y, ref_z, nbr_x, nbr_y, nbr_z;
	logic [ID_W-1:0] ref_id_out, nbr_id_out;
	logic signed [FORCE_W-1:0] force_x, force_y, force_z;
	logic force_valid;
	logic [NUM_FILTER-1:0] back_pressure;
	logic all_empty;

	// Expected results, keyed by neighbour ID
	logic exp_pending [ID_NUM];
	logic [ID_W-1:0] exp_ref [ID_NUM];
	logic signed [FORCE_W-1:0] exp_fx [ID_NUM];
	logic signed [FORCE_W-1:0] exp_fy [ID_NUM];
	logic signed [FORCE_W-1:0] exp_fz [ID_NUM];
	int exp_lane [ID_NUM];
	int exp_seq [ID_NUM];
	// Per-lane arrival order
	int lane_sent [NUM_FILTER];
	int lane_done [NUM_FILTER];
	int outstanding, next_id, cycle, last_send_cycle, last_out_cycle;
	logic [31:0] rng_state;

	lj_force_eval_unit lj_force_eval_unit_i
	(
		.clk(clk), .rst(rst), .in_valid(in_valid),
		.ref_id(ref_id), .nbr_id(nbr_id),
		.ref_x(ref_x), .ref_y(ref_y), .ref_z(ref_z),
		.nbr_x(nbr_x), .nbr_y(nbr_y), .nbr_z(nbr_z),
		.ref_id_out(ref_id_out), .nbr_id_out(nbr_id_out),
		.force_x(force_x), .force_y(force_y), .force_z(force_z),
		.force_valid(force_valid), .back_pressure(back_pressure), .all_empty(all_empty)
	);

	// 100 ns period
	always #50 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_id(input string name, input logic [ID_W-1:0] expected,
		input logic [ID_W-1:0] actual);
		if (actual !== expected)
			stop_run($sformatf("ERROR at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
	endtask

	task automatic check_force(input string name, input logic signed [FORCE_W-1:0] expected,
		input logic signed [FORCE_W-1:0] actual);
		if (actual !== expected)
			stop_run($sformatf("ERROR at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stop_run($sformatf("ERROR at %0t: %s expected %b, got %b",
				$time, name, expected, actual));
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
			stop_run($sformatf("ERROR at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw(input int span, output int value);
		rng_state = xorshift32(rng_state);
		value = int'(rng_state % span);
	endtask

	// First-order table interpolation, table entry a is (64 - a)^2
	function automatic int interp_mag(input int r2);
		int a, frac, t0, t1;
		a = r2 >> FRAC_W;
		frac = r2 & ((1 << FRAC_W) - 1);
		t0 = (LOOKUP_NUM - a) * (LOOKUP_NUM - a);
		t1 = (LOOKUP_NUM - a - 1) * (LOOKUP_NUM - a - 1);
		return t0 + (((t1 - t0) * frac) >>> FRAC_W);
	endfunction

	// Next drive slot, strobes drop unless staged again
	task automatic begin_cycle();
		@(posedge clk);
		#1;
		in_valid = '0;
	endtask

	// Drive one pair on a lane and record what it should produce
	task automatic stage_pair(input int lane, input int dx, input int dy, input int dz);
		int rx, ry, rz, rid, ddx, ddy, ddz, r2, mag;
		draw(4001, rx);
		draw(4001, ry);
		draw(4001, rz);
		draw(ID_NUM, rid);
		rx = rx - 2000;
		ry = ry - 2000;
		rz = rz - 2000;
		in_valid[lane] = 1'b1;
		ref_id[lane] = ID_W'(rid);
		nbr_id[lane] = ID_W'(next_id);
		ref_x[lane] = COORD_W'(rx);
		ref_y[lane] = COORD_W'(ry);
		ref_z[lane] = COORD_W'(rz);
		nbr_x[lane] = COORD_W'(rx + dx);
		nbr_y[lane] = COORD_W'(ry + dy);
		nbr_z[lane] = COORD_W'(rz + dz);
		// Model works from the driven coordinates
		ddx = int'($signed(nbr_x[lane])) - int'($signed(ref_x[lane]));
		ddy = int'($signed(nbr_y[lane])) - int'($signed(ref_y[lane]));
		ddz = int'($signed(nbr_z[lane])) - int'($signed(ref_z[lane]));
		r2 = ddx * ddx + ddy * ddy + ddz * ddz;
		last_send_cycle = cycle;
		if (r2 < CUTOFF_2)
		begin
			mag = interp_mag(r2);
			exp_pending[next_id] = 1'b1;
			exp_ref[next_id] = ID_W'(rid);
			exp_fx[next_id] = FORCE_W'(mag * ddx);
			exp_fy[next_id] = FORCE_W'(mag * ddy);
			exp_fz[next_id] = FORCE_W'(mag * ddz);
			exp_lane[next_id] = lane;
			exp_seq[next_id] = lane_sent[lane];
			lane_sent[lane]++;
			outstanding++;
		end
		next_id++;
	endtask

	// Offsets up to 63 per axis stay inside the cutoff
	task automatic stage_random(input int lane);
		int dx, dy, dz;
		draw(127, dx);
		draw(127, dy);
		draw(127, dz);
		stage_pair(lane, dx - 63, dy - 63, dz - 63);
	endtask

	task automatic wait_results(input int limit);
		int n;
		n = 0;
		while (outstanding != 0 && n < limit)
		begin
			@(negedge clk);
			#1;
			n++;
		end
		if (outstanding != 0)
			stop_run($sformatf("Timed out with %0d results still missing", outstanding));
	endtask

	// Drain, then idle past the force pipeline to catch stray results
	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (!(all_empty && outstanding == 0) && n < limit)
		begin
			@(negedge clk);
			#1;
			n++;
			// Bank empty leaves at most the force pipeline's pairs pending
			if (all_empty && outstanding > FORCE_LAT + 1)
				stop_run("all_empty rose while pairs were still buffered");
		end
		if (!(all_empty && outstanding == 0))
			stop_run("Timed out waiting for the unit to drain");
		repeat (FORCE_LAT + 2) @(negedge clk);
	endtask

	// Result checker
	always @(negedge clk)
	begin
		int nid, lane;
		if (!rst && force_valid === 1'b1)
		begin
			nid = int'(nbr_id_out);
			if (!exp_pending[nid])
				stop_run($sformatf("Unexpected result for neighbour ID %0d", nid));
			else
			begin
				lane = exp_lane[nid];
				if (exp_seq[nid] != lane_done[lane])
					stop_run($sformatf("Neighbour ID %0d left lane %0d out of order", nid, lane));
				check_id("ref_id_out", exp_ref[nid], ref_id_out);
				check_force("force_x", exp_fx[nid], force_x);
				check_force("force_y", exp_fy[nid], force_y);
				check_force("force_z", exp_fz[nid], force_z);
				exp_pending[nid] = 1'b0;
				lane_done[lane]++;
				outstanding--;
				last_out_cycle = cycle;
			end
		end
	end

	task automatic reset_values();
		@(negedge clk);
		check_flag("force_valid", 1'b0, force_valid);
		for (int l = 0; l < NUM_FILTER; l++)
			check_flag($sformatf("back_pressure[%0d]", l), 1'b0, back_pressure[l]);
		check_flag("all_empty", 1'b1, all_empty);
	endtask

	task automatic single_pair_latency();
		begin_cycle();
		// r2 = 525, index 2 with frac 13
		stage_pair(0, 10, -20, 5);
		begin_cycle();
		wait_results(4 * PAIR_LAT);
		check_count("force_valid latency", PAIR_LAT, last_out_cycle - last_send_cycle);
		wait_idle(50);
	endtask

	// At and beyond the cutoff mixed with pairs inside it
	task automatic cutoff_filtering();
		begin_cycle();
		stage_pair(0, 128, 0, 0);
		stage_pair(1, 30, 40, 0);
		begin_cycle();
		stage_pair(0, 10, 10, 10);
		stage_pair(1, 0, -128, 0);
		begin_cycle();
		stage_pair(0, 128, 1, 0);
		stage_pair(2, 127, -11, 6);
		begin_cycle();
		stage_pair(0, 200, -200, 90);
		stage_pair(3, 0, 0, -127);
		begin_cycle();
		stage_pair(1, -120, -50, -10);
		stage_pair(0, -5, 60, -70);
		begin_cycle();
		wait_idle(200);
	endtask

	// Top bin against entry 64, then frac zero on exact table points
	task automatic boundary_indices();
		begin_cycle();
		stage_pair(0, 127, 0, 0);
		stage_pair(1, 127, 5, 3);
		stage_pair(2, 127, -11, 6);
		stage_pair(3, -127, -9, -2);
		begin_cycle();
		stage_pair(0, 0, 96, 0);
		stage_pair(1, 16, 0, 0);
		stage_pair(2, 0, -48, 0);
		stage_pair(3, 0, 0, 64);
		begin_cycle();
		stage_pair(0, -80, 0, 0);
		begin_cycle();
		wait_idle(200);
	endtask

	task automatic four_lane_burst();
		for (int c = 0; c < 24; c++)
		begin
			begin_cycle();
			for (int l = 0; l < NUM_FILTER; l++)
				if (!back_pressure[l])
					stage_random(l);
		end
		begin_cycle();
		wait_idle(600);
	endtask

	// Lane 0 pushed hard while the other lanes compete for the pipeline
	task automatic lane_saturation();
		int sent0, n;
		logic saw_bp;
		sent0 = 0;
		n = 0;
		saw_bp = 1'b0;
		while (sent0 < 40 && n < 400)
		begin
			begin_cycle();
			n++;
			if (back_pressure[0])
			begin
				// A lane holding back pairs keeps the unit busy
				saw_bp = 1'b1;
				check_flag("all_empty", 1'b0, all_empty);
			end
			for (int l = 0; l < NUM_FILTER; l++)
			begin
				if (!back_pressure[l])
				begin
					stage_random(l);
					if (l == 0)
						sent0++;
				end
			end
		end
		begin_cycle();
		if (sent0 < 40)
			stop_run("Timed out feeding pairs into lane 0");
		if (!saw_bp)
			stop_run("back_pressure[0] never rose while lane 0 was saturated");
		wait_idle(800);
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = '0;
		ref_id = '0;
		nbr_id = '0;
		ref_x = '0;
		ref_y = '0;
		ref_z = '0;
		nbr_x = '0;
		nbr_y = '0;
		nbr_z = '0;
		rng_state = 32'd89;
		outstanding = 0;
		next_id = 0;
		cycle = 0;
		last_send_cycle = 0;
		last_out_cycle = 0;
		for (int i = 0; i < ID_NUM; i++)
			exp_pending[i] = 1'b0;
		for (int l = 0; l < NUM_FILTER; l++)
		begin
			lane_sent[l] = 0;
			lane_done[l] = 0;
		end
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_values();
		single_pair_latency();
		cutoff_filtering();
		boundary_indices();
		four_lane_burst();
		lane_saturation();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
common/lj_pkg.sv
filter_bank/filter_logic.sv
filter_bank/filter_arbiter.sv
filter_bank/filter_bank.sv
src/lj_force_pipeline.sv
src/lj_force_eval_unit.sv
sim/lj_force_eval_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the LJ force unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module lj_force_eval_tb -f files.f \
	--Mdir obj_dir -o lj_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/lj_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0
